/* Makefile */
# Verilator build and run of the shim testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_vtp -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vtb_vtp

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+.
vtp_pkg.sv
vtp_page_table.sv
vtp_xlate_chan.sv
vtp_rsp_inject.sv
vtp_shim.sv
vtp_shim_asserts.sv
tb_vtp.sv

/* tb_vtp.sv */
// Directed testbench for the translation shim; compile with all.f and run tb_vtp as the top
`timescale 1ns/100ps
`default_nettype none

`include "vtp_defs.svh"

module tb_vtp;

    import vtp_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    // Virtual line address that no loaded entry covers
    localparam logic [31:0] MISS_ADDR_A = {26'h3000001, 6'h05};
    localparam logic [31:0] MISS_ADDR_B = {26'h3000002, 6'h11};

    logic         clk;
    logic         reset;
    rd_req_t      afu_rd_req;
    wr_req_t      afu_wr_req;
    logic         afu_rd_almost_full;
    logic         afu_wr_almost_full;
    rd_rsp_t      afu_rd_rsp;
    rd_req_t      fiu_rd_req;
    wr_req_t      fiu_wr_req;
    logic         fiu_rd_almost_full;
    logic         fiu_wr_almost_full;
    rd_rsp_t      fiu_rd_rsp;
    logic         load_en;
    table_idx_t   load_idx;
    table_entry_t load_entry;
    logic         fault;
    line_addr_t   fault_vaddr;
    logic [15:0]  lfsr_state;
    int           cycles;

    vtp_shim u_dut (.*);

    bind vtp_shim vtp_shim_asserts u_asserts (
        .clk        (clk),
        .reset      (reset),
        .fiu_rd_req (fiu_rd_req),
        .fiu_wr_req (fiu_wr_req),
        .afu_rd_rsp (afu_rd_rsp),
        .fault      (fault)
    );

    // ========================================
    // Clock, timeout and helpers
    // ========================================

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES)
            begin
                $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Testbench failed");
                $fatal(1);
            end
        end
    end

    // Galois LFSR, one step for every bit handed out
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act)
        begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic load_page(input int idx, input logic big, input page_idx_t vp,
                             input page_idx_t pp);
        @(negedge clk);
        load_en    = 1'b1;
        load_idx   = table_idx_t'(idx);
        load_entry = '{entry_valid: 1'b1, big_page: big, vpage: vp, ppage: pp};
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // Streams requests through both channels and checks each output two cycles later
    task automatic stream_requests(input string name, input line_addr_t vaddr[$],
                                   input line_addr_t paddr[$], input logic virt);
        rd_req_t rd_exp[$];
        wr_req_t wr_exp[$];
        rd_req_t rd_in;
        wr_req_t wr_in;
        int      n;
        n = vaddr.size();
        for (int i = 0; i < n + 2; i++)
        begin
            @(negedge clk);
            if (i >= 2)
            begin
                check_value({name, "_rd"}, rd_exp.pop_front(), fiu_rd_req);
                check_value({name, "_wr"}, wr_exp.pop_front(), fiu_wr_req);
            end
            afu_rd_req = '0;
            afu_wr_req = '0;
            if (i < n)
            begin
                rd_in = '{valid: 1'b1, addr_is_virtual: virt, speculative: rand_bits(1),
                          cl_len: rand_bits(2), mdata: rand_bits(16), addr: vaddr[i]};
                wr_in = '{valid: 1'b1, addr_is_virtual: virt, cl_len: rand_bits(2),
                          mdata: rand_bits(16), data: rand_bits(64), addr: vaddr[i]};
                afu_rd_req = rd_in;
                afu_wr_req = wr_in;
                // The translated copy differs only in its address and virtual flag
                rd_in.addr_is_virtual = 1'b0;
                rd_in.addr            = paddr[i];
                wr_in.addr_is_virtual = 1'b0;
                wr_in.addr            = paddr[i];
                rd_exp.push_back(rd_in);
                wr_exp.push_back(wr_in);
            end
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic test_passthrough;
        line_addr_t a[$];
        for (int i = 0; i < 6; i++)
        begin
            a.push_back(rand_bits(32));
        end
        stream_requests("passthrough", a, a, 1'b0);
    endtask

    task automatic test_4k_translation;
        line_addr_t va[$];
        line_addr_t pa[$];
        logic [5:0] off;
        load_page(0, 1'b0, 26'h0001234, 26'h0ABCDE0);
        for (int i = 0; i < 8; i++)
        begin
            off = rand_bits(6);
            va.push_back({26'h0001234, off});
            pa.push_back({26'h0ABCDE0, off});
        end
        stream_requests("xlate_4k", va, pa, 1'b1);
    endtask

    task automatic test_2m_priority;
        line_addr_t va[$];
        line_addr_t pa[$];
        logic [5:0] off;
        load_page(1, 1'b0, 26'h0200005, 26'h0111111);
        load_page(2, 1'b1, 26'h0200000, 26'h0333000);
        load_page(3, 1'b1, 26'h0400000, 26'h0555000);
        load_page(4, 1'b0, 26'h0400003, 26'h0777777);
        off = rand_bits(6);
        // Slot 1 beats the 2 MB page in slot 2
        va.push_back({26'h0200005, off});
        pa.push_back({26'h0111111, off});
        // Outside the small page only the 2 MB page matches
        va.push_back({26'h0200007, off});
        pa.push_back({17'(26'h0333000 >> 9), 9'h007, off});
        // Slot 3 beats the 4 KB page in slot 4
        va.push_back({26'h0400003, off});
        pa.push_back({17'(26'h0555000 >> 9), 9'h003, off});
        stream_requests("xlate_2m", va, pa, 1'b1);
    endtask

    task automatic test_spec_miss;
        rd_rsp_t prev;
        rd_rsp_t drv;
        mdata_t  tag;
        int      errs;
        tag  = rand_bits(16);
        prev = '0;
        errs = 0;
        @(negedge clk);
        afu_rd_req = '{valid: 1'b1, addr_is_virtual: 1'b1, speculative: 1'b1,
                       cl_len: 2'd2, mdata: tag, addr: MISS_ADDR_A};
        for (int k = 0; k < 24; k++)
        begin
            @(negedge clk);
            afu_rd_req = '0;
            check_value("spec_no_req", 1'b0, fiu_rd_req.valid);
            if (prev.valid)
            begin
                check_value("spec_forward", prev, afu_rd_rsp);
            end
            else if (afu_rd_rsp.valid)
            begin
                check_value("spec_error", 1'b1, afu_rd_rsp.error);
                check_value("spec_mdata", tag, afu_rd_rsp.mdata);
                check_value("spec_cl_num", errs, afu_rd_rsp.cl_num);
                check_value("spec_last", errs == 2, afu_rd_rsp.last);
                errs++;
            end
            drv = '0;
            if (k < 12 && (k % 3) != 0)
            begin
                drv = '{valid: 1'b1, error: 1'b0, last: 1'b1, cl_num: 2'd0,
                        mdata: mdata_t'(k), data: rand_bits(64)};
            end
            fiu_rd_rsp = drv;
            prev       = drv;
        end
        check_value("spec_count", 3, errs);
    endtask

    task automatic test_hard_miss;
        @(negedge clk);
        // Speculative misses so far must not have raised the fault flag
        check_value("hard_fault_clear", 1'b0, fault);
        afu_rd_req = '{valid: 1'b1, addr_is_virtual: 1'b1, speculative: 1'b0,
                       cl_len: 2'd0, mdata: rand_bits(16), addr: MISS_ADDR_A};
        @(negedge clk);
        afu_rd_req = '0;
        afu_wr_req = '{valid: 1'b1, addr_is_virtual: 1'b1, cl_len: 2'd1,
                       mdata: rand_bits(16), data: rand_bits(64), addr: MISS_ADDR_B};
        @(negedge clk);
        afu_wr_req = '0;
        check_value("hard_rd_drop", 1'b0, fiu_rd_req.valid);
        @(negedge clk);
        check_value("hard_wr_drop", 1'b0, fiu_wr_req.valid);
        check_value("hard_fault", 1'b1, fault);
        repeat (3) @(negedge clk);
        check_value("hard_fault_vaddr", MISS_ADDR_A, fault_vaddr);
    endtask

    task automatic test_back_pressure;
        int errs;
        @(negedge clk);
        fiu_rd_almost_full = 1'b1;
        #1;
        check_value("bp_rd", 1'b1, afu_rd_almost_full);
        check_value("bp_wr_idle", 1'b0, afu_wr_almost_full);
        @(negedge clk);
        fiu_rd_almost_full = 1'b0;
        fiu_wr_almost_full = 1'b1;
        #1;
        check_value("bp_wr", 1'b1, afu_wr_almost_full);
        check_value("bp_rd_idle", 1'b0, afu_rd_almost_full);
        @(negedge clk);
        fiu_wr_almost_full = 1'b0;
        // Keep the response path busy so the FIFO only fills
        fiu_rd_rsp = '{valid: 1'b1, error: 1'b0, last: 1'b1, cl_num: 2'd0,
                       mdata: 16'h00AA, data: '0};
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            afu_rd_req = '{valid: 1'b1, addr_is_virtual: 1'b1, speculative: 1'b1,
                           cl_len: 2'd0, mdata: rand_bits(16), addr: MISS_ADDR_B};
        end
        @(negedge clk);
        afu_rd_req = '0;
        // Three headers are pending here and the fourth lands one cycle later
        @(negedge clk);
        check_value("bp_below_threshold", 1'b0, afu_rd_almost_full);
        repeat (3) @(negedge clk);
        check_value("bp_fifo_full", 1'b1, afu_rd_almost_full);
        fiu_rd_rsp = '0;
        errs = 0;
        for (int k = 0; k < 16; k++)
        begin
            @(negedge clk);
            if (afu_rd_rsp.valid && afu_rd_rsp.error)
            begin
                errs++;
            end
        end
        check_value("bp_drained", 4, errs);
        check_value("bp_fifo_clear", 1'b0, afu_rd_almost_full);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        lfsr_state         = 16'd63791;
        reset              = 1'b0;
        afu_rd_req         = '0;
        afu_wr_req         = '0;
        fiu_rd_almost_full = 1'b0;
        fiu_wr_almost_full = 1'b0;
        fiu_rd_rsp         = '0;
        load_en            = 1'b0;
        load_idx           = '0;
        load_entry         = '0;
        repeat (10) @(negedge clk);
        check_value("reset_fault", 1'b0, fault);
        check_value("reset_rd_af", 1'b0, afu_rd_almost_full);
        check_value("reset_wr_af", 1'b0, afu_wr_almost_full);
        check_value("reset_rd_valid", 1'b0, fiu_rd_req.valid);
        check_value("reset_wr_valid", 1'b0, fiu_wr_req.valid);
        check_value("reset_rsp_valid", 1'b0, afu_rd_rsp.valid);
        reset = 1'b1;
        test_passthrough();
        test_4k_translation();
        test_2m_priority();
        test_spec_miss();
        test_hard_miss();
        test_back_pressure();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vtp_defs.svh */
// Width and size macros for the translation shim, included by the package, the RTL and the testbench
`ifndef VTP_DEFS_SVH
`define VTP_DEFS_SVH

// ========================================
// Address geometry
// ========================================

// All addresses in the shim are cache-line addresses
`define VTP_LINE_ADDR_BITS 32

// Line offset within a 4 KB page (64 lines of 64 bytes)
`define VTP_4K_OFFSET_BITS 6

// Line offset within a 2 MB page
`define VTP_2M_OFFSET_BITS 15

// ========================================
// Storage sizes
// ========================================

// Number of slots in the fully associative page table
`define VTP_TABLE_ENTRIES 8

// Pending speculative-miss headers awaiting error responses
`define VTP_ERR_FIFO_DEPTH 8

// Occupancy at which the read channel reports almost full
`define VTP_ERR_FIFO_THRESHOLD 4

// Payload widths
`define VTP_MDATA_BITS 16
`define VTP_DATA_BITS 64

`endif

/* vtp_page_table.sv */
// Fully associative page table with a load port and two combinational lookup ports
`timescale 1ns/100ps
`default_nettype none

`include "vtp_defs.svh"

module vtp_page_table
(
    input  logic                  clk,
    input  logic                  reset,

    // Table load port, written at the clock edge
    input  logic                  load_en,
    input  vtp_pkg::table_idx_t   load_idx,
    input  vtp_pkg::table_entry_t load_entry,

    // Read channel lookup
    input  vtp_pkg::line_addr_t   rd_vaddr,
    output logic                  rd_hit,
    output vtp_pkg::line_addr_t   rd_paddr,

    // Write channel lookup
    input  vtp_pkg::line_addr_t   wr_vaddr,
    output logic                  wr_hit,
    output vtp_pkg::line_addr_t   wr_paddr
);

    import vtp_pkg::*;

    localparam int ENTRIES = `VTP_TABLE_ENTRIES;

    // Bits of a 4 KB page number that become offset within a 2 MB page
    localparam int BIG_EXTRA = `VTP_2M_OFFSET_BITS - `VTP_4K_OFFSET_BITS;

    typedef struct packed {
        logic       hit;
        line_addr_t paddr;
    } lookup_t;

    table_entry_t entries [ENTRIES];
    lookup_t      rd_result;
    lookup_t      wr_result;

    // ========================================
    // Storage and load port
    // ========================================

    // Reset empties the table by clearing every valid flag
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < ENTRIES; i++)
            begin
                entries[i].entry_valid <= 1'b0;
            end
        end
        else if (load_en)
        begin
            entries[load_idx] <= load_entry;
        end
    end

    // ========================================
    // Lookup
    // ========================================

    // Compare the full page number for 4 KB and only the upper bits for 2 MB
    function automatic logic entry_match(input table_entry_t entry, input line_addr_t vaddr);
        page_idx_t vpage;
        vpage = vaddr[`VTP_LINE_ADDR_BITS-1:`VTP_4K_OFFSET_BITS];
        if (!entry.entry_valid)
        begin
            return 1'b0;
        end
        if (entry.big_page)
        begin
            return entry.vpage[$bits(page_idx_t)-1:BIG_EXTRA] ==
                   vpage[$bits(page_idx_t)-1:BIG_EXTRA];
        end
        return entry.vpage == vpage;
    endfunction

    // Scan from the top down so that the lowest matching slot is the one kept
    function automatic lookup_t lookup(input line_addr_t vaddr);
        lookup_t result;
        result.hit   = 1'b0;
        result.paddr = vaddr;
        for (int i = ENTRIES - 1; i >= 0; i--)
        begin
            if (entry_match(entries[i], vaddr))
            begin
                result.hit = 1'b1;
                if (entries[i].big_page)
                begin
                    result.paddr = {entries[i].ppage[$bits(page_idx_t)-1:BIG_EXTRA],
                                    vaddr[`VTP_2M_OFFSET_BITS-1:0]};
                end
                else
                begin
                    result.paddr = {entries[i].ppage, vaddr[`VTP_4K_OFFSET_BITS-1:0]};
                end
            end
        end
        return result;
    endfunction

    // Both ports see the same table contents in the same cycle
    always_comb
    begin
        rd_result = lookup(rd_vaddr);
        wr_result = lookup(wr_vaddr);
    end

    assign rd_hit   = rd_result.hit;
    assign rd_paddr = rd_result.paddr;
    assign wr_hit   = wr_result.hit;
    assign wr_paddr = wr_result.paddr;

endmodule

`default_nettype wire

/* vtp_pkg.sv */
// Shared types of the translation shim; modules import it by wildcard inside their bodies
`default_nettype none

`include "vtp_defs.svh"

package vtp_pkg;

    // ========================================
    // Plain vector types
    // ========================================

    // Cache-line address, virtual or physical
    typedef logic [`VTP_LINE_ADDR_BITS-1:0] line_addr_t;

    // A 4 KB page number, the line address without its page offset
    typedef logic [`VTP_LINE_ADDR_BITS-`VTP_4K_OFFSET_BITS-1:0] page_idx_t;

    // Slot number in the page table
    typedef logic [$clog2(`VTP_TABLE_ENTRIES)-1:0] table_idx_t;

    // Number of lines in a request minus one, so 1 to 4 lines
    typedef logic [1:0] cl_len_t;

    // Requester tag, returned untouched with every response
    typedef logic [`VTP_MDATA_BITS-1:0] mdata_t;

    // One beat of line data
    typedef logic [`VTP_DATA_BITS-1:0] line_data_t;

    // ========================================
    // Packed structs
    // ========================================

    // For a big page only the upper bits of vpage and ppage are compared and used
    typedef struct packed {
        logic      entry_valid;
        logic      big_page;
        page_idx_t vpage;
        page_idx_t ppage;
    } table_entry_t;

    // Both request structs start with valid and addr_is_virtual and end with addr
    // So the channel pipeline finds those fields at the same bit positions
    typedef struct packed {
        logic       valid;
        logic       addr_is_virtual;
        logic       speculative;
        cl_len_t    cl_len;
        mdata_t     mdata;
        line_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic       valid;
        logic       addr_is_virtual;
        cl_len_t    cl_len;
        mdata_t     mdata;
        line_data_t data;
        line_addr_t addr;
    } wr_req_t;

    // Read response, one per line; last marks the final line of a request
    typedef struct packed {
        logic       valid;
        logic       error;
        logic       last;
        cl_len_t    cl_num;
        mdata_t     mdata;
        line_data_t data;
    } rd_rsp_t;

    // Error injector: idle on line 0 of the head entry, sending on later lines
    typedef enum logic {
        INJ_IDLE,
        INJ_SEND
    } inject_state_t;

endpackage

`default_nettype wire

/* vtp_rsp_inject.sv */
// Read response path that forwards FIU responses and fills idle cycles with miss errors
`timescale 1ns/100ps
`default_nettype none

`include "vtp_defs.svh"

module vtp_rsp_inject
(
    input  logic             clk,
    input  logic             reset,

    // Header of a speculative read that missed the table
    input  logic             enq_en,
    input  vtp_pkg::mdata_t  enq_mdata,
    input  vtp_pkg::cl_len_t enq_cl_len,

    // Response stream from the FIU and toward the AFU
    input  vtp_pkg::rd_rsp_t fiu_rsp,
    output vtp_pkg::rd_rsp_t afu_rsp,

    // Pending headers at or above threshold
    output logic             almost_full
);

    import vtp_pkg::*;

    localparam int DEPTH    = `VTP_ERR_FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    typedef struct packed {
        mdata_t  mdata;
        cl_len_t cl_len;
    } err_hdr_t;

    err_hdr_t            fifo_mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    err_hdr_t            head;
    logic                do_enq;
    logic                do_deq;
    logic                inject;
    logic                last_line;
    cl_len_t             line_cnt;
    cl_len_t             cur_line;
    inject_state_t       state;

    // ========================================
    // Header FIFO
    // ========================================

    // Writes beyond a full FIFO are lost; the almost-full margin prevents them
    assign do_enq = enq_en && (count != CNT_BITS'(DEPTH));
    assign head   = fifo_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            fifo_mem[wr_ptr] <= '{mdata: enq_mdata, cl_len: enq_cl_len};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            wr_ptr <= wr_ptr + PTR_BITS'(do_enq);
            rd_ptr <= rd_ptr + PTR_BITS'(do_deq);
            count  <= count + CNT_BITS'(do_enq) - CNT_BITS'(do_deq);
        end
    end

    assign almost_full = count >= CNT_BITS'(`VTP_ERR_FIFO_THRESHOLD);

    // ========================================
    // Injection control
    // ========================================

    // An error line goes out only when the FIU leaves the cycle empty
    assign inject    = !fiu_rsp.valid && (count != '0);
    assign cur_line  = (state == INJ_SEND) ? line_cnt : '0;
    assign last_line = cur_line == head.cl_len;
    assign do_deq    = inject && last_line;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state    <= INJ_IDLE;
            line_cnt <= '0;
        end
        else if (inject)
        begin
            if (last_line)
            begin
                state <= INJ_IDLE;
            end
            else
            begin
                state    <= INJ_SEND;
                line_cnt <= cur_line + 2'd1;
            end
        end
    end

    // FIU responses pass with one cycle of latency, error lines take the gaps
    always_ff @(posedge clk)
    begin
        afu_rsp <= fiu_rsp;
        if (inject)
        begin
            afu_rsp <= '{valid: 1'b1, error: 1'b1, last: last_line, cl_num: cur_line,
                         mdata: head.mdata, data: '0};
        end
        if (!reset)
        begin
            afu_rsp.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* vtp_shim.sv */
// Top of the translation shim between the AFU and the FIU, instantiated by the testbench
`timescale 1ns/100ps
`default_nettype none

`include "vtp_defs.svh"

module vtp_shim
(
    input  logic                  clk,
    input  logic                  reset,

    // AFU side
    input  vtp_pkg::rd_req_t      afu_rd_req,
    input  vtp_pkg::wr_req_t      afu_wr_req,
    output logic                  afu_rd_almost_full,
    output logic                  afu_wr_almost_full,
    output vtp_pkg::rd_rsp_t      afu_rd_rsp,

    // FIU side
    output vtp_pkg::rd_req_t      fiu_rd_req,
    output vtp_pkg::wr_req_t      fiu_wr_req,
    input  logic                  fiu_rd_almost_full,
    input  logic                  fiu_wr_almost_full,
    input  vtp_pkg::rd_rsp_t      fiu_rd_rsp,

    // Page table load port
    input  logic                  load_en,
    input  vtp_pkg::table_idx_t   load_idx,
    input  vtp_pkg::table_entry_t load_entry,

    // First non-speculative miss, held until reset
    output logic                  fault,
    output vtp_pkg::line_addr_t   fault_vaddr
);

    import vtp_pkg::*;

    line_addr_t rd_look_vaddr;
    line_addr_t rd_look_paddr;
    logic       rd_look_hit;
    line_addr_t wr_look_vaddr;
    line_addr_t wr_look_paddr;
    logic       wr_look_hit;
    logic       rd_miss_spec;
    logic       rd_miss_hard;
    logic       wr_miss_hard;
    line_addr_t rd_miss_vaddr;
    line_addr_t wr_miss_vaddr;
    logic       err_almost_full;

    // ========================================
    // Request channels
    // ========================================

    vtp_xlate_chan #(.REQ_BITS($bits(rd_req_t))) u_rd_chan (
        .clk            (clk),
        .reset          (reset),
        .req_in         (afu_rd_req),
        .is_speculative (afu_rd_req.speculative),
        .req_out        (fiu_rd_req),
        .look_vaddr     (rd_look_vaddr),
        .look_hit       (rd_look_hit),
        .look_paddr     (rd_look_paddr),
        .miss_spec      (rd_miss_spec),
        .miss_hard      (rd_miss_hard),
        .miss_vaddr     (rd_miss_vaddr)
    );

    // Writes are never speculative, so every write miss is a hard miss
    vtp_xlate_chan #(.REQ_BITS($bits(wr_req_t))) u_wr_chan (
        .clk            (clk),
        .reset          (reset),
        .req_in         (afu_wr_req),
        .is_speculative (1'b0),
        .req_out        (fiu_wr_req),
        .look_vaddr     (wr_look_vaddr),
        .look_hit       (wr_look_hit),
        .look_paddr     (wr_look_paddr),
        .miss_spec      (),
        .miss_hard      (wr_miss_hard),
        .miss_vaddr     (wr_miss_vaddr)
    );

    vtp_page_table u_page_table (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .load_idx   (load_idx),
        .load_entry (load_entry),
        .rd_vaddr   (rd_look_vaddr),
        .rd_hit     (rd_look_hit),
        .rd_paddr   (rd_look_paddr),
        .wr_vaddr   (wr_look_vaddr),
        .wr_hit     (wr_look_hit),
        .wr_paddr   (wr_look_paddr)
    );

    // ========================================
    // Responses and flow control
    // ========================================

    // The dropped request still carries its mdata and length at the FIU port
    vtp_rsp_inject u_rsp_inject (
        .clk         (clk),
        .reset       (reset),
        .enq_en      (rd_miss_spec),
        .enq_mdata   (fiu_rd_req.mdata),
        .enq_cl_len  (fiu_rd_req.cl_len),
        .fiu_rsp     (fiu_rd_rsp),
        .afu_rsp     (afu_rd_rsp),
        .almost_full (err_almost_full)
    );

    assign afu_rd_almost_full = fiu_rd_almost_full || err_almost_full;
    assign afu_wr_almost_full = fiu_wr_almost_full;

    // Sticky fault; the read channel wins when both channels miss together
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            fault <= 1'b0;
        end
        else if (!fault && (rd_miss_hard || wr_miss_hard))
        begin
            fault       <= 1'b1;
            fault_vaddr <= rd_miss_hard ? rd_miss_vaddr : wr_miss_vaddr;
        end
    end

endmodule

`default_nettype wire

/* vtp_shim_asserts.sv */
// Concurrent checks on the shim outputs, bound to every vtp_shim instance by the testbench
`timescale 1ns/100ps
`default_nettype none

module vtp_shim_asserts
(
    input  logic             clk,
    input  logic             reset,
    input  vtp_pkg::rd_req_t fiu_rd_req,
    input  vtp_pkg::wr_req_t fiu_wr_req,
    input  vtp_pkg::rd_rsp_t afu_rd_rsp,
    input  logic             fault
);

    import vtp_pkg::*;

    // A request reaching the FIU always carries a physical address
    rd_phys: assert property (@(posedge clk) disable iff (!reset)
        !(fiu_rd_req.valid && fiu_rd_req.addr_is_virtual))
        else $error("virtual read address reached the FIU");

    wr_phys: assert property (@(posedge clk) disable iff (!reset)
        !(fiu_wr_req.valid && fiu_wr_req.addr_is_virtual))
        else $error("virtual write address reached the FIU");

    // Error lines are real responses
    err_valid: assert property (@(posedge clk) disable iff (!reset)
        afu_rd_rsp.error |-> afu_rd_rsp.valid)
        else $error("error response without valid");

    // The fault flag is sticky
    fault_sticky: assert property (@(posedge clk) disable iff (!reset)
        !$fell(fault))
        else $error("fault fell without reset");

endmodule

`default_nettype wire

/* vtp_xlate_chan.sv */
// Two-stage translation pipeline for one request channel, shared by reads and writes
`timescale 1ns/100ps
`default_nettype none

`include "vtp_defs.svh"

module vtp_xlate_chan
#(
    parameter int REQ_BITS = 53
)
(
    input  logic                clk,
    input  logic                reset,

    // Request from the AFU and its speculative flag
    input  logic [REQ_BITS-1:0] req_in,
    input  logic                is_speculative,

    // Rebuilt request toward the FIU
    output logic [REQ_BITS-1:0] req_out,

    // Table lookup for the request held in stage 1
    output vtp_pkg::line_addr_t look_vaddr,
    input  logic                look_hit,
    input  vtp_pkg::line_addr_t look_paddr,

    // Miss report, aligned with req_out
    output logic                miss_spec,
    output logic                miss_hard,
    output vtp_pkg::line_addr_t miss_vaddr
);

    import vtp_pkg::*;

    // Valid and addr_is_virtual lead both request structs, the address ends them
    localparam int VALID_BIT = REQ_BITS - 1;
    localparam int VIRT_BIT  = REQ_BITS - 2;
    localparam int ADDR_MSB  = `VTP_LINE_ADDR_BITS - 1;

    logic [REQ_BITS-1:0] s1_req;
    logic                s1_spec;
    logic [REQ_BITS-1:0] s2_next;
    logic                s1_miss;
    line_addr_t          s1_addr;

    // ========================================
    // Stage 1: register the request
    // ========================================

    always_ff @(posedge clk)
    begin
        s1_req  <= req_in;
        s1_spec <= is_speculative;
        // Reset drops any request held in stage 1
        if (!reset)
        begin
            s1_req[VALID_BIT] <= 1'b0;
        end
    end

    assign s1_addr    = s1_req[ADDR_MSB:0];
    assign look_vaddr = s1_addr;

    // ========================================
    // Stage 2: rebuild with the physical address
    // ========================================

    // A virtual request either takes the translated address or is killed
    always_comb
    begin
        s2_next = s1_req;
        s1_miss = 1'b0;
        if (s1_req[VIRT_BIT])
        begin
            s2_next[VIRT_BIT] = 1'b0;
            if (look_hit)
            begin
                s2_next[ADDR_MSB:0] = look_paddr;
            end
            else
            begin
                // Dropped here; the miss outputs say what to do with it
                s2_next[VALID_BIT] = 1'b0;
                s1_miss            = s1_req[VALID_BIT];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        req_out    <= s2_next;
        miss_spec  <= s1_miss && s1_spec;
        miss_hard  <= s1_miss && !s1_spec;
        miss_vaddr <= s1_addr;
        if (!reset)
        begin
            req_out[VALID_BIT] <= 1'b0;
            miss_spec          <= 1'b0;
            miss_hard          <= 1'b0;
        end
    end

endmodule

`default_nettype wire
